// File: flist.f
verilog/obj_pkg.sv
verilog/obj_entry_if.sv
verilog/obj_table_scan.sv
verilog/obj_tile_draw.sv
verilog/obj_line_buffer.sv
verilog/obj_render.sv
dv/obj_render_sva.sv
dv/obj_render_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator and run; success only when the pass line appears in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module obj_render_tb -f flist.f -o obj_render_sim \
    && ./obj_dir/obj_render_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
    && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }

// File: dv/obj_render_tb.sv
// directed testbench for obj_render; table and ROM are models, ROM delay is the only random input
`timescale 1ns/1ps

module obj_render_tb import obj_pkg::*; ();

    localparam int cycle_limit = 6 * (table_entries * 40 + 2 * (line_w + 1));

    logic        clk;
    logic        rst;
    logic        start;
    logic [7:0]  vrender;
    logic        done;
    logic [7:0]  table_addr;
    logic [15:0] table_data;
    logic [19:0] rom_addr;
    logic        rom_half;
    logic        rom_cs;
    logic [31:0] rom_data;
    logic        rom_ok;
    logic        line_rd;
    logic [8:0]  line_rd_addr;
    pixel_t      line_rd_data;

    logic [15:0] tbl [256];       // object table of four words per entry
    pixel_t      exp_line [line_w];
    pixel_t      got_line [line_w];
    int          errors = 0;
    int          checks = 0;
    int          done_total = 0;
    int          cycles = 0;

    obj_render obj_render_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (!rst && done)
            done_total++;
        if (cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ROM row contents; code bit 15 makes tile columns 0-3 and 8-11 transparent
    function automatic logic [31:0] rom_word(input logic [19:0] addr, input logic half);
        logic [31:0] h;
        h = {addr, 11'd0, half} ^ 32'h5bd1e995;
        h = h * 32'h9e3779b1;
        h = h ^ (h >> 15);
        h = h * 32'h85ebca6b;
        h = h ^ (h >> 13);
        if (addr[19])
            h = h | 32'hf0f0f0f0;
        return h;
    endfunction

    initial begin
        logic [7:0] a;
        table_data = '0;
        forever begin
            @(posedge clk);
            a = table_addr;
            #1 table_data = tbl[a];  // one-cycle synchronous read
        end
    end

    initial begin
        logic        cs_q;
        logic        ok_q;
        logic [19:0] addr_q;
        logic        half_q;
        logic        rom_busy;
        int          rom_wait;
        rom_ok   = 1'b0;
        rom_data = '0;
        rom_busy = 1'b0;
        rom_wait = 0;
        void'($urandom(32'ha2a1));
        forever begin
            @(posedge clk);
            cs_q   = rom_cs;
            ok_q   = rom_ok;
            addr_q = rom_addr;
            half_q = rom_half;
            #1;
            if (rst || ok_q) begin  // data taken on this edge
                rom_ok   = 1'b0;
                rom_busy = 1'b0;
            end else if (cs_q) begin
                if (!rom_busy) begin
                    rom_busy = 1'b1;
                    rom_wait = 1 + $urandom % 6;
                end
                rom_wait = rom_wait - 1;
                if (rom_wait == 0) begin
                    rom_ok   = 1'b1;
                    rom_data = rom_word(addr_q, half_q);
                    rom_busy = 1'b0;
                end
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic compare_pixel(input string test, input int x, input pixel_t exp,
                                 input pixel_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s x=%0d: expected %h, actual %h", test, x, exp, act);
        end
    endtask

    task automatic compare_count(input string test, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("error %s done pulses: expected %0d, actual %0d", test, exp, act);
        end
    endtask

    task automatic clear_table();
        for (int i = 0; i < 256; i++)
            tbl[i] = 16'h0000;
    endtask

    task automatic set_entry(input int e, input logic [15:0] attr, input logic [15:0] code,
                             input logic [8:0] x, input logic [7:0] y);
        tbl[4 * e + word_attr] = attr;
        tbl[4 * e + word_code] = code;
        tbl[4 * e + word_x]    = {7'd0, x};
        tbl[4 * e + word_y]    = {8'd0, y};
    endtask

    // expected line with entries drawn in table order so later ones win
    task automatic render_ref(input logic [7:0] vr);
        logic [15:0] attr;
        logic [15:0] code;
        logic [8:0]  x;
        logic [7:0]  diff;
        logic [3:0]  row;
        logic [31:0] w;
        logic [3:0]  c;
        int          j;
        int          xa;
        for (int i = 0; i < line_w; i++)
            exp_line[i] = clear_pixel;
        for (int e = 0; e < table_entries; e++) begin
            attr = tbl[4 * e + word_attr];
            if (attr == end_attr)
                break;
            code = tbl[4 * e + word_code];
            x    = tbl[4 * e + word_x][8:0];
            diff = vr - tbl[4 * e + word_y][7:0];
            if (diff < 8'd16) begin
                row = attr[attr_vflip] ? 4'd15 - diff[3:0] : diff[3:0];
                for (int p = 0; p < 16; p++) begin
                    j  = attr[attr_hflip] ? 15 - p : p;  // tile column shown at x+p
                    w  = rom_word({code, row}, j >= 8);
                    c  = {w[31 - j % 8], w[23 - j % 8], w[15 - j % 8], w[7 - j % 8]};
                    xa = x + p;
                    if (xa < line_w && c != transp_colour)
                        exp_line[xa] = {attr[4:0], c};
                end
            end
        end
    endtask

    task automatic read_line();
        for (int a = 0; a <= line_w; a++) begin
            next_cycle();
            if (a > 0)
                got_line[a - 1] = line_rd_data;  // read issued one cycle earlier
            line_rd      = a < line_w;
            line_rd_addr = 9'(a);
        end
    endtask

    task automatic run_line(input string test, input logic [7:0] vr);
        int first;
        render_ref(vr);
        first   = done_total;
        vrender = vr;
        start   = 1'b1;
        next_cycle();
        start = 1'b0;
        while (done_total == first)
            next_cycle();
        read_line();
        for (int i = 0; i < line_w; i++)
            compare_pixel(test, i, exp_line[i], got_line[i]);
        compare_count(test, 1, done_total - first);
    endtask

    task automatic single_test();
        clear_table();
        set_entry(0, 16'h0005, 16'h0123, 9'd100, 8'd50);
        set_entry(1, end_attr, 16'h0000, 9'd0, 8'd0);
        run_line("single", 8'd53);
    endtask

    task automatic flip_test();
        clear_table();
        set_entry(0, 16'h0003, 16'h0200, 9'd10, 8'd90);   // plain reference copy
        set_entry(1, 16'h0023, 16'h0200, 9'd40, 8'd90);   // hflip
        set_entry(2, 16'h0047, 16'h0200, 9'd70, 8'd90);   // vflip
        set_entry(3, 16'h0069, 16'h0311, 9'd300, 8'd85);  // both
        set_entry(4, end_attr, 16'h0000, 9'd0, 8'd0);
        run_line("flip", 8'd94);
    endtask

    task automatic zone_end_test();
        clear_table();
        set_entry(0, 16'h0001, 16'h0400, 9'd20, 8'd121);   // starts below the line
        set_entry(1, 16'h0002, 16'h0401, 9'd60, 8'd104);   // ended just above
        set_entry(2, 16'h0003, 16'h0402, 9'd100, 8'd105);  // last row
        set_entry(3, 16'h0004, 16'h0403, 9'd140, 8'd120);  // first row
        set_entry(4, end_attr, 16'h0000, 9'd0, 8'd0);
        set_entry(5, 16'h0006, 16'h0404, 9'd180, 8'd118);  // behind the end marker
        run_line("zone_end", 8'd120);
    endtask

    task automatic transp_clip_test();
        clear_table();
        set_entry(0, 16'h0004, 16'h0500, 9'd200, 8'd30);
        set_entry(1, 16'h0009, 16'h8500, 9'd200, 8'd30);  // see-through columns
        set_entry(2, 16'h000c, 16'h0501, 9'd440, 8'd30);
        set_entry(3, 16'h0006, 16'h0502, 9'd504, 8'd30);  // tail passes address 511
        set_entry(4, end_attr, 16'h0000, 9'd0, 8'd0);
        run_line("transp_clip", 8'd33);
    endtask

    task automatic many_test();
        clear_table();
        for (int e = 0; e < table_entries; e++)
            set_entry(e, 16'(e * 13 % 128), 16'(e * 977), 9'(e * 29 % 480),
                      8'(150 - e * 7 % 24));
        run_line("many", 8'd150);
    endtask

    task automatic clear_test();
        int first;
        first = done_total;
        read_line();
        for (int i = 0; i < line_w; i++)
            compare_pixel("clear", i, clear_pixel, got_line[i]);
        compare_count("clear", 0, done_total - first);
    endtask

    initial begin
        rst          = 1'b1;
        start        = 1'b0;
        vrender      = '0;
        line_rd      = 1'b0;
        line_rd_addr = '0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        single_test();
        flip_test();
        zone_end_test();
        transp_clip_test();
        many_test();
        clear_test();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: dv/obj_render_sva.sv
// ROM port and entry handshake checks bound into obj_tile_draw; all checks idle during rst
`timescale 1ns/1ps

module obj_render_sva import obj_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        rom_cs,
    input logic        rom_ok,
    input logic [19:0] rom_addr,
    input logic        rom_half,
    input logic        pix_wr,
    input logic        valid,
    input logic        ready,
    input logic [15:0] code,
    input logic [8:0]  x,
    input logic [3:0]  vsub,
    input logic        hflip,
    input pal_t        pal
);

    // request stays up and unchanged until rom_ok
    rom_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr) && $stable(rom_half))
        else $error("rom request changed or dropped before rom_ok");

    rom_release: assert property (@(posedge clk) disable iff (rst)
        rom_cs && rom_ok |=> !rom_cs)
        else $error("rom_cs still high after the data was taken");

    entry_hold: assert property (@(posedge clk) disable iff (rst)
        valid && !ready |=> valid && $stable({code, x, vsub, hflip, pal}))
        else $error("entry changed while waiting for ready");

    no_pix_in_wait: assert property (@(posedge clk) disable iff (rst)
        rom_cs |-> !pix_wr)
        else $error("pixel write during a rom wait");

endmodule

bind obj_tile_draw obj_render_sva u_sva (
    .clk      (clk),
    .rst      (rst),
    .rom_cs   (rom_cs),
    .rom_ok   (rom_ok),
    .rom_addr (rom_addr),
    .rom_half (rom_half),
    .pix_wr   (pix_wr),
    .valid    (ent.valid),
    .ready    (ent.ready),
    .code     (ent.code),
    .x        (ent.x),
    .vsub     (ent.vsub),
    .hflip    (ent.hflip),
    .pal      (ent.pal)
);

// File: verilog/obj_render.sv
// object line renderer top; start is ignored until done has pulsed for the previous line
`timescale 1ns/1ps

module obj_render import obj_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic [7:0]  vrender,        // line being prepared
    output logic        done,
    output logic [7:0]  table_addr,     // entry index and word
    input  logic [15:0] table_data,
    output logic [19:0] rom_addr,
    output logic        rom_half,
    output logic        rom_cs,
    input  logic [31:0] rom_data,
    input  logic        rom_ok,
    input  logic        line_rd,
    input  logic [8:0]  line_rd_addr,
    output pixel_t      line_rd_data
);

    logic       draw_idle;
    logic       pix_wr;
    logic [9:0] pix_addr;
    pixel_t     pix_data;

    obj_entry_if ent_if ();

    obj_table_scan u_scan (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .vrender    (vrender),
        .table_addr (table_addr),
        .table_data (table_data),
        .draw_idle  (draw_idle),
        .done       (done),
        .ent        (ent_if.src)
    );

    obj_tile_draw u_draw (
        .clk       (clk),
        .rst       (rst),
        .ent       (ent_if.dst),
        .rom_addr  (rom_addr),
        .rom_half  (rom_half),
        .rom_cs    (rom_cs),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .pix_wr    (pix_wr),
        .pix_addr  (pix_addr),
        .pix_data  (pix_data),
        .draw_idle (draw_idle)
    );

    obj_line_buffer u_buf (
        .clk          (clk),
        .rst          (rst),
        .pix_wr       (pix_wr),
        .pix_addr     (pix_addr),
        .pix_data     (pix_data),
        .line_rd      (line_rd),
        .line_rd_addr (line_rd_addr),
        .line_rd_data (line_rd_data)
    );

endmodule

// File: verilog/obj_line_buffer.sv
// single line buffer; render and scanout share it, so a line must be read out before the next draw
`timescale 1ns/1ps

module obj_line_buffer import obj_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       pix_wr,
    input  logic [9:0] pix_addr,
    input  pixel_t     pix_data,
    input  logic       line_rd,
    input  logic [8:0] line_rd_addr,
    output pixel_t     line_rd_data
);

    pixel_t mem [buf_depth];
    logic   wr_ok;
    logic   visible;
    logic   opaque;

    assign visible = pix_addr < 10'(line_w);           // clip at the right edge
    assign opaque  = pix_data.colour != transp_colour;
    assign wr_ok   = pix_wr && visible && opaque;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < buf_depth; i++) begin
                mem[i] <= clear_pixel;
            end
            line_rd_data <= clear_pixel;
        end else begin
            // scanout read, leaves the location empty
            if (line_rd) begin
                line_rd_data       <= mem[line_rd_addr];
                mem[line_rd_addr]  <= clear_pixel;
            end
            if (wr_ok)
                mem[pix_addr[8:0]] <= pix_data;  // later sprite wins
        end
    end

endmodule

// File: verilog/obj_tile_draw.sv
// 16-pixel tile row drawer; rom_ok may arrive after any number of cycles, one entry at a time
`timescale 1ns/1ps

module obj_tile_draw import obj_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    obj_entry_if.dst    ent,
    output logic [19:0] rom_addr,
    output logic        rom_half,
    output logic        rom_cs,
    input  logic [31:0] rom_data,
    input  logic        rom_ok,
    output logic        pix_wr,
    output logic [9:0]  pix_addr,
    output pixel_t      pix_data,
    output logic        draw_idle
);

    draw_state_t state;
    logic [2:0]  pcnt;     // pixel within the half
    logic        second;   // working on the second half
    logic        hflip_r;
    pal_t        pal_r;
    logic [31:0] pxl;      // planar word being shifted out
    logic [9:0]  xpos;

    // four bit planes, one byte each
    function automatic logic [3:0] plane_colour(input logic [31:0] p, input logic flip);
        plane_colour = flip ? {p[24], p[16], p[8], p[0]} : {p[31], p[23], p[15], p[7]};
    endfunction

    assign ent.ready = state == drw_idle;
    assign draw_idle = state == drw_idle;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= drw_idle;
            rom_cs <= 1'b0;
            pix_wr <= 1'b0;
            pcnt   <= '0;
            second <= 1'b0;
        end else begin
            pix_wr <= 1'b0;
            case (state)
                drw_idle: begin
                    if (ent.valid) begin
                        rom_cs <= 1'b1;
                        second <= 1'b0;
                        state  <= drw_fetch;
                    end
                end
                drw_fetch: begin
                    if (rom_ok) begin  // data captured this edge
                        rom_cs <= 1'b0;
                        pcnt   <= '0;
                        state  <= drw_shift;
                    end
                end
                drw_shift: begin
                    pix_wr <= 1'b1;
                    pcnt   <= pcnt + 3'd1;
                    if (pcnt == 3'd7)
                        state <= second ? drw_idle : drw_next_half;
                end
                drw_next_half: begin
                    rom_cs <= 1'b1;
                    second <= 1'b1;
                    state  <= drw_fetch;
                end
                default: state <= drw_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            drw_idle: begin
                if (ent.valid) begin
                    rom_addr <= {ent.code, ent.vsub};
                    rom_half <= ent.hflip;  // flipped tiles start from the other half
                    hflip_r  <= ent.hflip;
                    pal_r    <= ent.pal;
                    xpos     <= {1'b0, ent.x};
                end
            end
            drw_fetch: begin
                if (rom_ok)
                    pxl <= rom_data;
            end
            drw_shift: begin
                pix_addr        <= xpos;
                xpos            <= xpos + 10'd1;  // may run past the line, buffer clips
                pix_data.pal    <= pal_r;
                pix_data.colour <= plane_colour(pxl, hflip_r);
                pxl             <= hflip_r ? pxl >> 1 : pxl << 1;
            end
            drw_next_half: rom_half <= ~rom_half;
            default: ;
        endcase
    end

endmodule

// File: verilog/obj_table_scan.sv
// object table walker; table read data must follow the address by exactly one cycle
`timescale 1ns/1ps

module obj_table_scan import obj_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic [7:0]  vrender,
    output logic [7:0]  table_addr,
    input  logic [15:0] table_data,
    input  logic        draw_idle,
    output logic        done,
    obj_entry_if.src    ent
);

    scan_state_t state;
    logic [1:0]  wcnt;      // word on table_data this cycle
    entry_idx_t  ent_idx;
    logic        last_ent;  // no more entries to read
    logic        at_last;
    logic [15:0] attr;
    logic [7:0]  ypos;
    logic [7:0]  vdiff;
    logic        in_zone;

    assign vdiff   = vrender - ypos;
    assign in_zone = vdiff < 8'd16;
    assign at_last = ent_idx == entry_idx_t'(table_entries - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= scan_idle;
            table_addr <= '0;
            wcnt       <= '0;
            ent_idx    <= '0;
            last_ent   <= 1'b0;
            ent.valid  <= 1'b0;
            done       <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                scan_idle: begin
                    if (start) begin  // word 0 already presented while idle
                        state      <= scan_read_words;
                        table_addr <= table_addr + 8'd1;
                        wcnt       <= '0;
                        ent_idx    <= '0;
                        last_ent   <= 1'b0;
                    end
                end
                scan_read_words: begin
                    wcnt <= wcnt + 2'd1;
                    if (wcnt == word_y)
                        state <= scan_check;  // address now on next entry
                    else
                        table_addr <= table_addr + 8'd1;
                end
                scan_check: begin
                    ent_idx <= ent_idx + 1'b1;
                    if (attr == end_attr || at_last)
                        last_ent <= 1'b1;
                    if (attr != end_attr && in_zone) begin
                        ent.valid <= 1'b1;
                        state     <= scan_handoff;
                    end else if (attr == end_attr || at_last) begin
                        state <= scan_handoff;  // only wait for the drawer
                    end else begin
                        state      <= scan_read_words;
                        table_addr <= table_addr + 8'd1;
                    end
                end
                scan_handoff: begin
                    if (ent.valid) begin
                        if (ent.ready) begin
                            ent.valid <= 1'b0;
                            if (!last_ent) begin
                                state      <= scan_read_words;
                                table_addr <= table_addr + 8'd1;
                            end
                        end
                    end else if (draw_idle) begin
                        done       <= 1'b1;
                        state      <= scan_idle;
                        table_addr <= '0;
                    end
                end
                default: state <= scan_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == scan_read_words) begin
            case (wcnt)
                word_attr: attr     <= table_data;
                word_code: ent.code <= table_data;
                word_x:    ent.x    <= table_data[8:0];
                word_y:    ypos     <= table_data[7:0];
            endcase
        end
        if (state == scan_check) begin
            ent.vsub  <= attr[attr_vflip] ? 4'd15 - vdiff[3:0] : vdiff[3:0];
            ent.hflip <= attr[attr_hflip];
            ent.pal   <= attr[4:0];
        end
    end

endmodule

// File: verilog/obj_entry_if.sv
// one decoded sprite entry; fields must stay stable while valid is high and ready is low
`timescale 1ns/1ps

interface obj_entry_if import obj_pkg::*; ();

    logic        valid;
    logic        ready;
    logic [15:0] code;   // tile code, upper rom address bits
    logic [8:0]  x;      // left pixel of the tile
    logic [3:0]  vsub;   // tile row, vflip already applied
    logic        hflip;
    pal_t        pal;

    modport src (
        output valid,
        input  ready,
        output code,
        output x,
        output vsub,
        output hflip,
        output pal
    );

    modport dst (
        input  valid,
        output ready,
        input  code,
        input  x,
        input  vsub,
        input  hflip,
        input  pal
    );

endinterface

// File: verilog/obj_pkg.sv
// table layout and pixel format for the object line renderer; 448-pixel line and 64 entries only
package obj_pkg;

    // line geometry
    localparam int unsigned line_w        = 448;  // visible pixels per line
    localparam int unsigned buf_depth     = 512;  // line buffer locations
    localparam int unsigned table_entries = 64;   // entries scanned per line

    // object table
    localparam logic [15:0] end_attr = 16'hff00;  // attr value that ends the table

    localparam logic [1:0] word_attr = 2'd0;
    localparam logic [1:0] word_code = 2'd1;
    localparam logic [1:0] word_x    = 2'd2;
    localparam logic [1:0] word_y    = 2'd3;

    localparam int unsigned attr_vflip = 6;  // bit positions in the attr word
    localparam int unsigned attr_hflip = 5;

    typedef logic [4:0] pal_t;
    typedef logic [5:0] entry_idx_t;  // entry number within the table

    // palette in the upper bits, colour index in the lower four
    typedef struct packed {
        pal_t       pal;
        logic [3:0] colour;
    } pixel_t;

    localparam logic [3:0] transp_colour = 4'd15;   // never lands in the buffer
    localparam pixel_t     clear_pixel   = 9'h1ff;  // empty location

    typedef enum logic [1:0] {
        scan_idle,
        scan_read_words,
        scan_check,
        scan_handoff
    } scan_state_t;

    typedef enum logic [1:0] {
        drw_idle,
        drw_fetch,
        drw_shift,
        drw_next_half
    } draw_state_t;

endpackage
